//--- include/mips_cfg.svh
`ifndef MIPS_CFG_SVH
`define MIPS_CFG_SVH

// Datapath width in bits
`define MIPS_XLEN 32

// Architectural register count with r0 reading as zero
`define MIPS_NREGS 32

// Data memory depth in words
// Word index comes from the address bits above the byte offset
`define MIPS_DMEM_WORDS 64

`endif

//--- hdl/mips_pkg.sv
`include "mips_cfg.svh"

package mips_pkg;

	////////////////////////////////////////////////////////////
	// Instruction encodings
	////////////////////////////////////////////////////////////

	typedef enum logic [5:0] {
		OP_RTYPE = 6'b000000,
		OP_J     = 6'b000010,
		OP_BEQ   = 6'b000100,
		OP_BNE   = 6'b000101,
		OP_ADDI  = 6'b001000,
		OP_ADDIU = 6'b001001,
		OP_SLTI  = 6'b001010,
		OP_SLTIU = 6'b001011,
		OP_ANDI  = 6'b001100,
		OP_ORI   = 6'b001101,
		OP_XORI  = 6'b001110,
		OP_LUI   = 6'b001111,
		OP_LB    = 6'b100000,
		OP_LH    = 6'b100001,
		OP_LW    = 6'b100011,
		OP_LBU   = 6'b100100,
		OP_LHU   = 6'b100101,
		OP_LWU   = 6'b100111,
		OP_SB    = 6'b101000,
		OP_SH    = 6'b101001,
		OP_SW    = 6'b101011
	} opcode_e;

	typedef enum logic [5:0] {
		FN_JR   = 6'b001000,
		FN_JALR = 6'b001001,
		FN_ADD  = 6'b100000,
		FN_ADDU = 6'b100001,
		FN_SUB  = 6'b100010,
		FN_SUBU = 6'b100011,
		FN_AND  = 6'b100100,
		FN_OR   = 6'b100101,
		FN_XOR  = 6'b100110,
		FN_NOR  = 6'b100111,
		FN_SLT  = 6'b101010,
		FN_SLTU = 6'b101011
	} funct_e;

	// ALU class from the main decoder
	typedef enum logic [1:0] {
		ALU_ADD   = 2'd0,
		ALU_FUNCT = 2'd2
	} alu_op_e;

	// Memory lane width and extension
	typedef enum logic [2:0] {
		TRUNK_WORD   = 3'd0,
		TRUNK_BYTE_S = 3'd1,
		TRUNK_HALF_S = 3'd2,
		TRUNK_BYTE_U = 3'd3,
		TRUNK_HALF_U = 3'd4
	} trunk_e;

	////////////////////////////////////////////////////////////
	// Stage payloads
	////////////////////////////////////////////////////////////

	typedef struct packed {
		logic    reg_dst;
		logic    alu_src;
		logic    mem_to_reg;
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    branch;
		alu_op_e alu_op;
		trunk_e  trunk;
	} ctrl_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		opcode_e               opcode;
		funct_e                funct;
		logic [`MIPS_XLEN-1:0] rs_data;
		logic [`MIPS_XLEN-1:0] rt_data;
		logic [`MIPS_XLEN-1:0] imm;
		logic [4:0]            dest;
	} id_ex_t;

	typedef struct packed {
		logic                  valid;
		ctrl_t                 ctrl;
		logic [`MIPS_XLEN-1:0] alu_res;
		logic [`MIPS_XLEN-1:0] store_data;
		logic [4:0]            dest;
	} ex_mem_t;

	typedef struct packed {
		logic                  valid;
		logic [4:0]            rd;
		logic [`MIPS_XLEN-1:0] data;
	} wb_t;

	typedef struct packed {
		logic valid;
		logic taken;
	} br_t;

endpackage

//--- hdl/control_decode.sv
module control_decode (
	input  logic               enable,
	input  mips_pkg::opcode_e  opcode,
	input  mips_pkg::funct_e   funct,
	output mips_pkg::ctrl_t    ctrl
);

	import mips_pkg::*;

	// Memory opcodes pick their lane width and all others use a word
	function automatic trunk_e trunk_of(input opcode_e op);
		trunk_e mode;
		case (op)
			OP_LB:
				mode = TRUNK_BYTE_S;
			OP_LH:
				mode = TRUNK_HALF_S;
			OP_LBU, OP_SB:
				mode = TRUNK_BYTE_U;
			OP_LHU, OP_SH:
				mode = TRUNK_HALF_U;
			default:
				mode = TRUNK_WORD;
		endcase
		return mode;
	endfunction

	always_comb
	begin
		// Bubble or unknown opcode leaves everything clear
		ctrl = '0;
		if (enable)
		begin
			case (opcode)
				OP_RTYPE:
				begin
					if (funct == FN_JR || funct == FN_JALR)
					begin
						// No link write on JALR
						ctrl.branch = 1'b1;
					end
					else
					begin
						ctrl.reg_dst   = 1'b1;
						ctrl.reg_write = 1'b1;
						ctrl.alu_op    = ALU_FUNCT;
					end
				end

				OP_LB, OP_LH, OP_LW, OP_LWU, OP_LBU, OP_LHU:
				begin
					ctrl.alu_src    = 1'b1;
					ctrl.mem_read   = 1'b1;
					ctrl.reg_write  = 1'b1;
					ctrl.mem_to_reg = 1'b1;
					ctrl.trunk      = trunk_of(opcode);
				end

				OP_SB, OP_SH, OP_SW:
				begin
					ctrl.alu_src   = 1'b1;
					ctrl.mem_write = 1'b1;
					ctrl.trunk     = trunk_of(opcode);
				end

				OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI,
				OP_LUI, OP_SLTI, OP_SLTIU:
				begin
					ctrl.alu_src   = 1'b1;
					ctrl.reg_write = 1'b1;
					ctrl.alu_op    = ALU_FUNCT;
				end

				OP_BEQ, OP_BNE, OP_J:
				begin
					ctrl.branch = 1'b1;
				end

				default:
				begin
					ctrl = '0;
				end
			endcase
		end
	end

endmodule

//--- hdl/decode_stage.sv
`include "mips_cfg.svh"

module decode_stage (
	input  logic             clk,
	input  logic             rst,
	input  logic [31:0]      instr,
	input  logic             instr_valid,
	input  mips_pkg::wb_t    wb,
	output mips_pkg::id_ex_t id_ex
);

	import mips_pkg::*;

	logic [`MIPS_XLEN-1:0] regs [`MIPS_NREGS] = '{default: '0};

	opcode_e               opcode;
	funct_e                funct;
	logic [4:0]            rs;
	logic [4:0]            rt;
	logic [4:0]            rd;
	ctrl_t                 ctrl;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	logic [`MIPS_XLEN-1:0] imm;
	id_ex_t                id_ex_d;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct  = funct_e'(instr[5:0]);
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];

	control_decode u_control_decode (
		.enable (instr_valid),
		.opcode (opcode),
		.funct  (funct),
		.ctrl   (ctrl)
	);

	////////////////////////////////////////////////////////////
	// Register file
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk)
	begin
		if (wb.valid && wb.rd != 5'd0)
			regs[wb.rd] <= wb.data;
	end

	// Pending writeback bypasses the array
	function automatic logic [`MIPS_XLEN-1:0] read_reg(input logic [4:0] idx);
		logic [`MIPS_XLEN-1:0] val;
		val = regs[idx];
		if (idx == 5'd0)
			val = '0;
		else if (wb.valid && wb.rd == idx)
			val = wb.data;
		return val;
	endfunction

	always_comb
	begin
		rs_data = read_reg(rs);
		rt_data = read_reg(rt);
	end

	// Logical immediates are zero extended
	always_comb
	begin
		if (opcode == OP_ANDI || opcode == OP_ORI || opcode == OP_XORI)
			imm = {{(`MIPS_XLEN-16){1'b0}}, instr[15:0]};
		else
			imm = {{(`MIPS_XLEN-16){instr[15]}}, instr[15:0]};
	end

	always_comb
	begin
		id_ex_d.valid   = instr_valid;
		id_ex_d.ctrl    = ctrl;
		id_ex_d.opcode  = opcode;
		id_ex_d.funct   = funct;
		id_ex_d.rs_data = rs_data;
		id_ex_d.rt_data = rt_data;
		id_ex_d.imm     = imm;
		id_ex_d.dest    = ctrl.reg_dst ? rd : rt;
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			id_ex.valid <= 1'b0;
			id_ex.ctrl  <= '0;
		end
		else
		begin
			id_ex <= id_ex_d;
		end
	end

endmodule

//--- hdl/execute_stage.sv
`include "mips_cfg.svh"

module execute_stage (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::id_ex_t  id_ex,
	output mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::br_t     br
);

	import mips_pkg::*;

	typedef enum logic [3:0] {
		AF_ADD,
		AF_SUB,
		AF_AND,
		AF_OR,
		AF_XOR,
		AF_NOR,
		AF_SLT,
		AF_SLTU,
		AF_LUI,
		AF_NONE
	} alu_fn_e;

	alu_fn_e               alu_fn;
	logic [`MIPS_XLEN-1:0] op_a;
	logic [`MIPS_XLEN-1:0] op_b;
	logic [`MIPS_XLEN-1:0] alu_res;
	logic                  taken;

	////////////////////////////////////////////////////////////
	// ALU control
	////////////////////////////////////////////////////////////

	always_comb
	begin
		// Address and compare class just adds
		alu_fn = AF_ADD;
		if (id_ex.ctrl.alu_op == ALU_FUNCT)
		begin
			if (id_ex.opcode == OP_RTYPE)
			begin
				case (id_ex.funct)
					FN_ADD, FN_ADDU: alu_fn = AF_ADD;
					FN_SUB, FN_SUBU: alu_fn = AF_SUB;
					FN_AND:          alu_fn = AF_AND;
					FN_OR:           alu_fn = AF_OR;
					FN_XOR:          alu_fn = AF_XOR;
					FN_NOR:          alu_fn = AF_NOR;
					FN_SLT:          alu_fn = AF_SLT;
					FN_SLTU:         alu_fn = AF_SLTU;
					default:         alu_fn = AF_NONE;
				endcase
			end
			else
			begin
				case (id_ex.opcode)
					OP_ADDI, OP_ADDIU: alu_fn = AF_ADD;
					OP_ANDI:           alu_fn = AF_AND;
					OP_ORI:            alu_fn = AF_OR;
					OP_XORI:           alu_fn = AF_XOR;
					OP_SLTI:           alu_fn = AF_SLT;
					OP_SLTIU:          alu_fn = AF_SLTU;
					OP_LUI:            alu_fn = AF_LUI;
					default:           alu_fn = AF_NONE;
				endcase
			end
		end
	end

	assign op_a = id_ex.rs_data;
	assign op_b = id_ex.ctrl.alu_src ? id_ex.imm : id_ex.rt_data;

	always_comb
	begin
		alu_res = '0;
		case (alu_fn)
			AF_ADD:  alu_res = op_a + op_b;
			AF_SUB:  alu_res = op_a - op_b;
			AF_AND:  alu_res = op_a & op_b;
			AF_OR:   alu_res = op_a | op_b;
			AF_XOR:  alu_res = op_a ^ op_b;
			AF_NOR:  alu_res = ~(op_a | op_b);
			AF_SLT:  alu_res[0] = $signed(op_a) < $signed(op_b);
			AF_SLTU: alu_res[0] = op_a < op_b;
			AF_LUI:  alu_res = op_b << 16;
			default: alu_res = '0;
		endcase
	end

	// Jumps are unconditional
	always_comb
	begin
		case (id_ex.opcode)
			OP_BEQ:  taken = id_ex.rs_data == id_ex.rt_data;
			OP_BNE:  taken = id_ex.rs_data != id_ex.rt_data;
			default: taken = 1'b1;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			ex_mem.valid <= 1'b0;
			ex_mem.ctrl  <= '0;
			br           <= '0;
		end
		else
		begin
			ex_mem.valid      <= id_ex.valid;
			ex_mem.ctrl       <= id_ex.ctrl;
			ex_mem.alu_res    <= alu_res;
			ex_mem.store_data <= id_ex.rt_data;
			ex_mem.dest       <= id_ex.dest;
			br.valid          <= id_ex.valid && id_ex.ctrl.branch;
			br.taken          <= taken;
		end
	end

endmodule

//--- hdl/memory_stage.sv
`include "mips_cfg.svh"

module memory_stage (
	input  logic              clk,
	input  logic              rst,
	input  mips_pkg::ex_mem_t ex_mem,
	output mips_pkg::wb_t     wb
);

	import mips_pkg::*;

	localparam int NBYTES  = `MIPS_XLEN / 8;
	localparam int WORD_AW = $clog2(`MIPS_DMEM_WORDS);

	logic [`MIPS_XLEN-1:0] mem [`MIPS_DMEM_WORDS] = '{default: '0};

	logic [WORD_AW-1:0]    word_idx;
	logic [1:0]            byte_sel;
	logic [NBYTES-1:0]     wr_mask;
	logic [`MIPS_XLEN-1:0] wr_data;
	logic [`MIPS_XLEN-1:0] rd_word;
	logic [7:0]            lane_byte;
	logic [15:0]           lane_half;
	logic [`MIPS_XLEN-1:0] load_data;

	assign word_idx = ex_mem.alu_res[WORD_AW+1:2];
	assign byte_sel = ex_mem.alu_res[1:0];

	////////////////////////////////////////////////////////////
	// Store lanes
	////////////////////////////////////////////////////////////

	always_comb
	begin
		wr_mask = '1;
		wr_data = ex_mem.store_data;
		case (ex_mem.ctrl.trunk)
			TRUNK_BYTE_S, TRUNK_BYTE_U:
			begin
				wr_mask = NBYTES'(1) << byte_sel;
				wr_data = {NBYTES{ex_mem.store_data[7:0]}};
			end
			TRUNK_HALF_S, TRUNK_HALF_U:
			begin
				wr_mask = byte_sel[1] ? 4'b1100 : 4'b0011;
				wr_data = {(NBYTES/2){ex_mem.store_data[15:0]}};
			end
			default:
			begin
				wr_mask = '1;
			end
		endcase
	end

	// Byte lanes outside the mask keep their old contents
	always_ff @(posedge clk)
	begin
		if (ex_mem.valid && ex_mem.ctrl.mem_write)
		begin
			for (int i = 0; i < NBYTES; i++)
			begin
				if (wr_mask[i])
					mem[word_idx][8*i +: 8] <= wr_data[8*i +: 8];
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Load narrowing
	////////////////////////////////////////////////////////////

	assign rd_word   = mem[word_idx];
	assign lane_byte = rd_word[8*byte_sel +: 8];
	assign lane_half = byte_sel[1] ? rd_word[31:16] : rd_word[15:0];

	always_comb
	begin
		case (ex_mem.ctrl.trunk)
			TRUNK_BYTE_S: load_data = {{(`MIPS_XLEN-8){lane_byte[7]}}, lane_byte};
			TRUNK_HALF_S: load_data = {{(`MIPS_XLEN-16){lane_half[15]}}, lane_half};
			TRUNK_BYTE_U: load_data = {{(`MIPS_XLEN-8){1'b0}}, lane_byte};
			TRUNK_HALF_U: load_data = {{(`MIPS_XLEN-16){1'b0}}, lane_half};
			default:      load_data = rd_word;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			wb.valid <= 1'b0;
		end
		else
		begin
			// r0 writes never leave this stage
			wb.valid <= ex_mem.valid && ex_mem.ctrl.reg_write && ex_mem.dest != 5'd0;
			wb.rd    <= ex_mem.dest;
			if (ex_mem.ctrl.mem_to_reg && ex_mem.ctrl.mem_read)
				wb.data <= load_data;
			else
				wb.data <= ex_mem.alu_res;
		end
	end

endmodule

//--- hdl/mips_pipe_top.sv
module mips_pipe_top (
	input  logic          clk,
	input  logic          rst,
	input  logic [31:0]   instr,
	input  logic          instr_valid,
	output mips_pkg::wb_t wb,
	output mips_pkg::br_t br
);

	import mips_pkg::*;

	id_ex_t  id_ex;
	ex_mem_t ex_mem;

	decode_stage u_decode_stage (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb          (wb),
		.id_ex       (id_ex)
	);

	execute_stage u_execute_stage (
		.clk    (clk),
		.rst    (rst),
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.br     (br)
	);

	// Writeback record also feeds the register file
	memory_stage u_memory_stage (
		.clk    (clk),
		.rst    (rst),
		.ex_mem (ex_mem),
		.wb     (wb)
	);

endmodule

//--- dv/mips_pipe_assertions.sv
module mips_pipe_assertions (
	input logic          clk,
	input logic          rst,
	input logic          instr_valid,
	input mips_pkg::wb_t wb,
	input mips_pkg::br_t br
);

	int   reset_fails = 0;
	int   bubble_br_fails = 0;
	int   bubble_wb_fails = 0;
	int   rd_fails = 0;
	int   fail_count;
	logic armed = 1'b0;

	assign fail_count = reset_fails + bubble_br_fails + bubble_wb_fails + rd_fails;

	// Skip the very first edge before any register has been reset
	always @(posedge clk)
	begin
		armed <= 1'b1;
	end

	////////////////////////////////////////////////////////////
	// Port rules
	////////////////////////////////////////////////////////////

	reset_quiet: assert property (@(posedge clk)
		armed && ($past(rst) || $past(rst, 2)) |-> !wb.valid && !br.valid)
	else
	begin
		reset_fails++;
		$error("wb or br valid during reset or the cycle after it");
	end

	// Branch result trails its slot by two edges and writeback by three
	bubble_no_br: assert property (@(posedge clk) disable iff (rst)
		armed && !$past(instr_valid, 2) |-> !br.valid)
	else
	begin
		bubble_br_fails++;
		$error("idle slot produced a branch record");
	end

	bubble_no_wb: assert property (@(posedge clk) disable iff (rst)
		armed && !$past(instr_valid, 3) |-> !wb.valid)
	else
	begin
		bubble_wb_fails++;
		$error("idle slot produced a writeback record");
	end

	wb_rd_nonzero: assert property (@(posedge clk) disable iff (rst)
		wb.valid |-> wb.rd != 5'd0)
	else
	begin
		rd_fails++;
		$error("writeback record addresses r0");
	end

endmodule

bind mips_pipe_top mips_pipe_assertions u_assertions (
	.clk         (clk),
	.rst         (rst),
	.instr_valid (instr_valid),
	.wb          (wb),
	.br          (br)
);

//--- dv/mips_pipe_tb.sv
module mips_pipe_tb;

	import mips_pkg::*;

	localparam int CLK_PERIOD   = 8;
	localparam int RESET_CYCLES = 8;
	localparam int REC_WORDS    = 5;
	localparam int MAX_WORDS    = REC_WORDS * 128;

	logic        clk = 1'b0;
	logic        rst;
	logic [31:0] instr;
	logic        instr_valid;
	wb_t         wb;
	br_t         br;

	logic [31:0] tdata [MAX_WORDS];
	logic [31:0] instr_q [$];
	int          bubble_q [$];
	wb_t         exp_wb_q [$];
	br_t         exp_br_q [$];

	int          wb_seen = 0;
	int          br_seen = 0;
	int          wb_errors = 0;
	int          br_errors = 0;
	int          missing_errors = 0;
	int          assert_errors = 0;
	int unsigned limit_cycles = 0;

	always #(CLK_PERIOD / 2) clk = ~clk;

	mips_pipe_top UUT (
		.clk         (clk),
		.rst         (rst),
		.instr       (instr),
		.instr_valid (instr_valid),
		.wb          (wb),
		.br          (br)
	);

	////////////////////////////////////////////////////////////
	// Stimulus file
	////////////////////////////////////////////////////////////

	// Five words per line of instr, spacing, expect kind, rd or taken and data
	task automatic load_testdata();
		int          idx;
		int          bubbles;
		logic [31:0] kind;
		logic [31:0] spacing;
		wb_t         wrec;
		br_t         brec;
		bit          done;
		idx = 0;
		done = 1'b0;
		$readmemh("dv/mips_testdata.txt", tdata);
		while (!done && idx + REC_WORDS <= MAX_WORDS)
		begin
			kind = tdata[idx + 2];
			if (kind == 32'd0 || kind == 32'd1 || kind == 32'd2)
			begin
				spacing = tdata[idx + 1];
				bubbles = int'(spacing[3:0]);
				// Bit 4 marks an entry that tolerates extra idle slots
				if (spacing[4])
					bubbles += int'($urandom % 3);
				instr_q.push_back(tdata[idx]);
				bubble_q.push_back(bubbles);
				if (kind == 32'd1)
				begin
					wrec.valid = 1'b1;
					wrec.rd    = tdata[idx + 3][4:0];
					wrec.data  = tdata[idx + 4];
					exp_wb_q.push_back(wrec);
				end
				else if (kind == 32'd2)
				begin
					brec.valid = 1'b1;
					brec.taken = tdata[idx + 3][0];
					exp_br_q.push_back(brec);
				end
				idx += REC_WORDS;
			end
			else
			begin
				done = 1'b1;
			end
		end
	endtask

	////////////////////////////////////////////////////////////
	// Result checks
	////////////////////////////////////////////////////////////

	task automatic check_wb(input wb_t got, input wb_t exp);
		if (got.rd !== exp.rd)
		begin
			wb_errors++;
			$display("MISMATCH time=%0t wb.rd got=%0d expected=%0d", $time, got.rd, exp.rd);
		end
		if (got.data !== exp.data)
		begin
			wb_errors++;
			$display("MISMATCH time=%0t wb.data got=%h expected=%h",
				$time, got.data, exp.data);
		end
	endtask

	task automatic check_br(input br_t got, input br_t exp);
		if (got.taken !== exp.taken)
		begin
			br_errors++;
			$display("MISMATCH time=%0t br.taken got=%b expected=%b",
				$time, got.taken, exp.taken);
		end
	endtask

	// Outputs settle well before the falling edge
	always @(negedge clk)
	begin
		if (!rst)
		begin
			if (wb.valid === 1'b1)
			begin
				if (wb_seen >= exp_wb_q.size())
				begin
					wb_errors++;
					$display("Unexpected writeback to r%0d at time %0t", wb.rd, $time);
				end
				else
				begin
					check_wb(wb, exp_wb_q[wb_seen]);
				end
				wb_seen++;
			end
			if (br.valid === 1'b1)
			begin
				if (br_seen >= exp_br_q.size())
				begin
					br_errors++;
					$display("Unexpected branch report at time %0t", $time);
				end
				else
				begin
					check_br(br, exp_br_q[br_seen]);
				end
				br_seen++;
			end
		end
	end

	////////////////////////////////////////////////////////////
	// Watchdog
	////////////////////////////////////////////////////////////

	initial
	begin
		wait (limit_cycles != 0);
		#(limit_cycles * CLK_PERIOD);
		$display("Timeout: the run did not finish within %0d cycles", limit_cycles);
		$display("Simulation failed");
		$finish;
	end

	initial
	begin
		int total_bubbles;
		rst = 1'b1;
		instr = '0;
		instr_valid = 1'b0;
		total_bubbles = 0;
		void'($urandom(32'h25ca015b));
		load_testdata();
		if (instr_q.size() == 0)
		begin
			missing_errors++;
			$display("No instructions could be read from the test data file");
		end
		foreach (bubble_q[i])
			total_bubbles += bubble_q[i];
		limit_cycles = instr_q.size() + total_bubbles + RESET_CYCLES + 20;

		repeat (RESET_CYCLES) @(posedge clk);
		#1;
		rst = 1'b0;

		foreach (instr_q[i])
		begin
			@(posedge clk);
			#1;
			instr = instr_q[i];
			instr_valid = 1'b1;
			// Idle slots carry junk words that must be ignored
			repeat (bubble_q[i])
			begin
				@(posedge clk);
				#1;
				instr = $urandom;
				instr_valid = 1'b0;
			end
		end
		@(posedge clk);
		#1;
		instr = '0;
		instr_valid = 1'b0;
		repeat (6) @(posedge clk);
		@(negedge clk);
		#1;

		if (wb_seen < exp_wb_q.size())
		begin
			missing_errors++;
			$display("%0d expected writeback records never appeared", exp_wb_q.size() - wb_seen);
		end
		if (br_seen < exp_br_q.size())
		begin
			missing_errors++;
			$display("%0d expected branch records never appeared", exp_br_q.size() - br_seen);
		end
		assert_errors = UUT.u_assertions.fail_count;

		$display("Errors: wb %0d, br %0d, missing %0d, assertions %0d",
			wb_errors, br_errors, missing_errors, assert_errors);
		if (wb_errors + br_errors + missing_errors + assert_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

//--- dv/mips_testdata.txt
// instr    spacing  expect  rd/taken  data
// spacing: idle slots after this one, bit 4 adds 0 to 2 random ones; expect: 0 none, 1 wb, 2 br, 3 end
20010005 00 1 01 00000005  // addi r1, r0, 5
2002fffd 00 1 02 fffffffd  // addi r2, r0, -3
34038001 00 1 03 00008001  // ori r3, r0, 0x8001
3c041234 00 1 04 12340000  // lui r4, 0x1234
00222820 00 1 05 00000002  // add r5, r1, r2 via write-through
00223022 10 1 06 00000008  // sub
00643824 00 1 07 00000000  // and
00644025 00 1 08 12348001  // or
00414826 10 1 09 fffffff8  // xor
00235027 00 1 0a ffff7ffa  // nor
0041582a 00 1 0b 00000001  // slt
0041602b 10 1 0c 00000000  // sltu
284dfffe 00 1 0d 00000001  // slti r13, r2, -2
2c2effff 00 1 0e 00000001  // sltiu r14, r1, -1
304fff0f 00 1 0f 0000ff0d  // andi
3830ffff 10 1 10 0000fffa  // xori
24915678 00 1 11 12345678  // addiu r17, r4, 0x5678
00429021 00 1 12 fffffffa  // addu
00289823 01 1 13 edcb8004  // subu, then one idle slot
ac110010 00 0 00 00000000  // sw r17, 16(r0)
8c140010 00 1 14 12345678  // lw
80150011 00 1 15 00000056  // lb byte 1
a0020012 00 0 00 00000000  // sb r2, 18(r0) merges into the word
80160012 00 1 16 fffffffd  // lb
90170012 10 1 17 000000fd  // lbu
a4030010 00 0 00 00000000  // sh r3, 16(r0)
84180010 00 1 18 ffff8001  // lh
94190012 00 1 19 000012fd  // lhu upper half
9c1a0010 10 1 1a 12fd8001  // lwu
901b0010 00 1 1b 00000001  // lbu byte 0
10210004 00 2 01 00000000  // beq r1, r1
10220004 00 2 00 00000000  // beq r1, r2
14220004 10 2 01 00000000  // bne r1, r2
16910004 00 2 00 00000000  // bne r20, r17
08000100 00 2 01 00000000  // j
00200008 00 2 01 00000000  // jr r1
0020f809 02 2 01 00000000  // jalr, no link write
fc000000 00 0 00 00000000  // unknown opcode
20200007 02 0 00 00000000  // addi r0 is dropped
0001e020 00 1 1c 00000005  // add r28, r0, r1
201d0100 02 1 1d 00000100  // addi r29
23be0001 00 1 1e 00000101  // addi r30, r29, 1
00000000 00 3 00 00000000

//--- flist.f
+incdir+include
hdl/mips_pkg.sv
hdl/control_decode.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/memory_stage.sv
hdl/mips_pipe_top.sv
dv/mips_pipe_assertions.sv
dv/mips_pipe_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the pipeline testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module mips_pipe_tb -f flist.f -o Vmips_pipe_tb
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

# Keep running past assertion errors so the testbench reports them
./obj_dir/Vmips_pipe_tb +verilator+error+limit+1000 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "Simulator exited with status $status"
	exit 1
fi

if grep -q "Simulation failed" "$LOG"; then
	exit 1
fi
exit 0
